// File: rv_decode_pkg.sv
/* RV64I decode types and encodings shared by every stage
   XLEN and ILEN are fixed; the lane count is a module parameter */
`default_nettype none

package rv_decode_pkg;

  // data, pc and instruction widths
  localparam int XLEN      = 64;
  localparam int ILEN      = 32;
  localparam int REG_IDX_W = 5;

  // base opcodes, RV64I only
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_MISC_MEM  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

  // funct3 values that gate legality
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_FENCE   = 3'b000;
  localparam logic [2:0] F3_FENCE_I = 3'b001;
  localparam logic [2:0] F3_PRIV    = 3'b000;

  // funct7: base form and the sub/sra form
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // whole-word system instructions
  localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
  localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

  typedef enum logic [2:0] {
    FMT_NONE, FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_CSRI
  } inst_fmt_e;

  typedef struct packed {
    logic [6:0]           funct7;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]          imm11_0;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]           imm11_5;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [4:0]           imm4_0;
    logic [6:0]           opcode;
  } s_fmt_t;

  // branch offset bits are scattered, bit 0 implied zero
  typedef struct packed {
    logic                 imm12;
    logic [5:0]           imm10_5;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [3:0]           imm4_1;
    logic                 imm11;
    logic [6:0]           opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]          imm31_12;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                 imm20;
    logic [9:0]           imm10_1;
    logic                 imm11;
    logic [7:0]           imm19_12;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } j_fmt_t;

  // one instruction word, read through the view of its format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_word_u;

  typedef struct packed {
    inst_fmt_e            fmt;
    logic [REG_IDX_W-1:0] rs1;
    logic                 rs1_ren;
    logic [REG_IDX_W-1:0] rs2;
    logic                 rs2_ren;
    logic [REG_IDX_W-1:0] rd;
    logic                 rd_wen;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      target;
    logic [XLEN-1:0]      link;
  } uop_t;

  // flat bundle width: width words above a base pc
  function automatic int bundle_w(input int width);
    return width * ILEN + XLEN;
  endfunction

endpackage

`default_nettype wire

// File: decode_in_stage.sv
/* input register for fetch bundles; i_bundle must hold while i_valid waits on o_ready
   o_ready follows i_ready combinationally when the stage is full */
`timescale 1ns/10ps
`default_nettype none

module decode_in_stage
  import rv_decode_pkg::*;
#(
  parameter int DECODE_WIDTH = 2
) (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_valid,
  input  logic [bundle_w(DECODE_WIDTH)-1:0] i_bundle,
  input  logic                              i_ready,
  output logic                              o_ready,
  output logic                              o_valid,
  output logic [bundle_w(DECODE_WIDTH)-1:0] o_bundle
);

  // held bundle and its occupancy flag
  logic                              valid_q;
  logic [bundle_w(DECODE_WIDTH)-1:0] bundle_q;
  logic                              load;

  // take a new bundle when empty or when the held one leaves now
  assign o_ready = !valid_q || i_ready;
  assign load    = i_valid && o_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else if (o_ready) begin
      // drops to empty if nothing new arrives
      valid_q <= i_valid;
    end
  end

  // payload only moves on a transfer
  always_ff @(posedge i_clk) begin
    if (load) begin
      bundle_q <= i_bundle;
    end
  end

  assign o_valid  = valid_q;
  assign o_bundle = bundle_q;

endmodule

`default_nettype wire

// File: lane_decoder.sv
/* combinational RV64I decode of one slot; lane pc is base pc plus 4*LANE
   CSR immediate forms carry the zero-extended zimm and enable no register */
`timescale 1ns/10ps
`default_nettype none

module lane_decoder
  import rv_decode_pkg::*;
#(
  parameter int LANE = 0
) (
  input  inst_word_u      i_inst,
  input  logic [XLEN-1:0] i_base_pc,
  output uop_t            o_uop,
  output logic            o_illegal
);

  logic [6:0]      opcode;
  logic [2:0]      f3;
  logic [6:0]      f7;
  logic            op_imm_ok;
  logic            op_imm32_ok;
  logic            op_ok;
  logic            op32_ok;
  inst_fmt_e       fmt;
  logic            is_link;
  logic            rs1_ren;
  logic            rs2_ren;
  logic            rd_wen;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] lane_pc;

  // control fields sit at the same place in every view
  assign opcode = i_inst.r_fmt.opcode;
  assign f3     = i_inst.r_fmt.funct3;
  assign f7     = i_inst.r_fmt.funct7;

  // slot offset inside the fetch bundle
  assign lane_pc = i_base_pc + (XLEN'(LANE) << 2);

  // rv64 shifts take a 6-bit shamt, so only inst[31:26] is checked
  always_comb begin
    case (f3)
      F3_SLL:     op_imm_ok = (f7[6:1] == F7_BASE[6:1]);
      F3_SRL_SRA: op_imm_ok = (f7[6:1] == F7_BASE[6:1]) || (f7[6:1] == F7_ALT[6:1]);
      default:    op_imm_ok = 1'b1;
    endcase
  end

  // word forms: addiw, slliw, srliw, sraiw
  assign op_imm32_ok = (f3 == F3_ADD_SUB)
                    || (f3 == F3_SLL && f7 == F7_BASE)
                    || (f3 == F3_SRL_SRA && (f7 == F7_BASE || f7 == F7_ALT));

  // alt funct7 only for sub and sra
  assign op_ok = (f7 == F7_BASE)
              || (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));

  // addw subw sllw srlw sraw
  assign op32_ok = (f7 == F7_BASE && (f3 == F3_ADD_SUB || f3 == F3_SLL || f3 == F3_SRL_SRA))
                || (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));

  // opcode match picks the format, anything left over stays FMT_NONE
  always_comb begin
    fmt     = FMT_NONE;
    is_link = 1'b0;
    case (opcode)
      OPC_LUI, OPC_AUIPC: fmt = FMT_U;
      OPC_JAL: begin
        fmt     = FMT_J;
        is_link = 1'b1;
      end
      OPC_JALR: begin
        if (f3 == 3'b000) begin
          fmt     = FMT_I;
          is_link = 1'b1;
        end
      end
      // funct3 010 and 011 are unused branch slots
      OPC_BRANCH:    if (f3[2:1] != 2'b01) fmt = FMT_B;
      // lb lh lw ld lbu lhu lwu
      OPC_LOAD:      if (f3 != 3'b111) fmt = FMT_I;
      // sb sh sw sd
      OPC_STORE:     if (!f3[2]) fmt = FMT_S;
      OPC_OP_IMM:    if (op_imm_ok) fmt = FMT_I;
      OPC_OP_IMM_32: if (op_imm32_ok) fmt = FMT_I;
      OPC_OP:        if (op_ok) fmt = FMT_R;
      OPC_OP_32:     if (op32_ok) fmt = FMT_R;
      OPC_MISC_MEM:  if (f3 == F3_FENCE || f3 == F3_FENCE_I) fmt = FMT_I;
      OPC_SYSTEM: begin
        if (f3 == F3_PRIV) begin
          // only ecall and ebreak, exact words
          if (i_inst == INST_ECALL || i_inst == INST_EBREAK) fmt = FMT_I;
        end else if (f3[1:0] != 2'b00) begin
          // csrrw/s/c use rs1, the immediate forms reuse it as zimm
          fmt = f3[2] ? FMT_CSRI : FMT_I;
        end
      end
      default: fmt = FMT_NONE;
    endcase
  end

  // register enables by format
  assign rs1_ren = (fmt inside {FMT_R, FMT_I, FMT_S, FMT_B});
  assign rs2_ren = (fmt inside {FMT_R, FMT_S, FMT_B});
  assign rd_wen  = (fmt inside {FMT_R, FMT_I, FMT_U, FMT_J});

  // sign-extended immediate through the matching view
  always_comb begin
    case (fmt)
      FMT_I: imm = {{(XLEN-12){i_inst.i_fmt.imm11_0[11]}}, i_inst.i_fmt.imm11_0};
      FMT_S: imm = {{(XLEN-12){i_inst.s_fmt.imm11_5[6]}},
                    i_inst.s_fmt.imm11_5, i_inst.s_fmt.imm4_0};
      FMT_B: imm = {{(XLEN-13){i_inst.b_fmt.imm12}}, i_inst.b_fmt.imm12,
                    i_inst.b_fmt.imm11, i_inst.b_fmt.imm10_5,
                    i_inst.b_fmt.imm4_1, 1'b0};
      FMT_U: imm = {{(XLEN-32){i_inst.u_fmt.imm31_12[19]}},
                    i_inst.u_fmt.imm31_12, 12'b0};
      FMT_J: imm = {{(XLEN-21){i_inst.j_fmt.imm20}}, i_inst.j_fmt.imm20,
                    i_inst.j_fmt.imm19_12, i_inst.j_fmt.imm11,
                    i_inst.j_fmt.imm10_1, 1'b0};
      // zimm is unsigned
      FMT_CSRI: imm = {{(XLEN-REG_IDX_W){1'b0}}, i_inst.i_fmt.rs1};
      default: imm = '0;
    endcase
  end

  // disabled index fields read zero
  assign o_uop.fmt     = fmt;
  assign o_uop.rs1     = rs1_ren ? i_inst.r_fmt.rs1 : '0;
  assign o_uop.rs1_ren = rs1_ren;
  assign o_uop.rs2     = rs2_ren ? i_inst.r_fmt.rs2 : '0;
  assign o_uop.rs2_ren = rs2_ren;
  assign o_uop.rd      = rd_wen ? i_inst.r_fmt.rd : '0;
  assign o_uop.rd_wen  = rd_wen;
  assign o_uop.imm     = imm;

  // pc-relative target for branches and jal only
  assign o_uop.target  = (fmt == FMT_B || fmt == FMT_J) ? lane_pc + imm : '0;
  // return address for jal and jalr
  assign o_uop.link    = is_link ? lane_pc + XLEN'(4) : '0;

  assign o_illegal = (fmt == FMT_NONE);

endmodule

`default_nettype wire

// File: decode_out_stage.sv
/* output register for decoded bundles; o_uops and o_illegal hold while i_ready is low
   o_ready depends combinationally on i_ready */
`timescale 1ns/10ps
`default_nettype none

module decode_out_stage
  import rv_decode_pkg::*;
#(
  parameter int DECODE_WIDTH = 2
) (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_valid,
  input  uop_t [DECODE_WIDTH-1:0]       i_uops,
  input  logic [DECODE_WIDTH-1:0]       i_illegal_lanes,
  input  logic                          i_ready,
  output logic                          o_ready,
  output logic                          o_valid,
  output uop_t [DECODE_WIDTH-1:0]       o_uops,
  output logic                          o_illegal
);

  logic                    valid_q;
  uop_t [DECODE_WIDTH-1:0] uops_q;
  logic                    illegal_q;
  logic                    load;

  // same accept rule as the input register
  assign o_ready = !valid_q || i_ready;
  assign load    = i_valid && o_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else if (o_ready) begin
      valid_q <= i_valid;
    end
  end

  // any bad lane marks the whole bundle
  always_ff @(posedge i_clk) begin
    if (load) begin
      uops_q    <= i_uops;
      illegal_q <= |i_illegal_lanes;
    end
  end

  assign o_valid   = valid_q;
  assign o_uops    = uops_q;
  assign o_illegal = illegal_q;

endmodule

`default_nettype wire

// File: rv_decode_top.sv
/* two-register decode pipe; i_bundle is {word[W-1] .. word[0], base_pc}, pc in the low bits
   lane n decodes word[n] at base_pc + 4*n */
`timescale 1ns/10ps
`default_nettype none

module rv_decode_top
  import rv_decode_pkg::*;
#(
  parameter int DECODE_WIDTH = 2
) (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_valid,
  input  logic [bundle_w(DECODE_WIDTH)-1:0] i_bundle,
  input  logic                              i_ready,
  output logic                              o_ready,
  output logic                              o_valid,
  output uop_t [DECODE_WIDTH-1:0]           o_uops,
  output logic                              o_illegal
);

  // view of the flat bundle
  typedef struct packed {
    inst_word_u [DECODE_WIDTH-1:0] insts;
    logic [XLEN-1:0]               base_pc;
  } fetch_bundle_t;

  fetch_bundle_t           held_bundle;
  logic                    in_valid;
  logic                    in_ready;
  uop_t [DECODE_WIDTH-1:0] lane_uops;
  logic [DECODE_WIDTH-1:0] lane_illegal;

  decode_in_stage #(
    .DECODE_WIDTH(DECODE_WIDTH)
  ) u_in_stage (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_bundle(i_bundle),
    .i_ready (in_ready),
    .o_ready (o_ready),
    .o_valid (in_valid),
    .o_bundle(held_bundle)
  );

  // one decoder per slot, all reading the held bundle
  for (genvar n = 0; n < DECODE_WIDTH; n++) begin : g_lane
    lane_decoder #(
      .LANE(n)
    ) u_lane (
      .i_inst   (held_bundle.insts[n]),
      .i_base_pc(held_bundle.base_pc),
      .o_uop    (lane_uops[n]),
      .o_illegal(lane_illegal[n])
    );
  end

  decode_out_stage #(
    .DECODE_WIDTH(DECODE_WIDTH)
  ) u_out_stage (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_valid        (in_valid),
    .i_uops         (lane_uops),
    .i_illegal_lanes(lane_illegal),
    .i_ready        (i_ready),
    .o_ready        (in_ready),
    .o_valid        (o_valid),
    .o_uops         (o_uops),
    .o_illegal      (o_illegal)
  );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
/* testbench clock and synchronous reset pulse
   reset drops on a falling edge after RESET_CYCLES rising edges */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // held high through the first RESET_CYCLES rising edges
  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_rv_decode.sv
/* directed testbench for the two-lane decode pipe, inputs change on falling edges
   expected micro-ops are built from the base ISA field layout */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_decode
  import rv_decode_pkg::*;
();

  localparam int DECODE_WIDTH = 2;
  localparam int TIMEOUT      = 40;
  localparam int STREAM_LEN   = 48;

  logic                              clk;
  logic                              rst;
  logic                              i_valid;
  logic                              i_ready;
  logic [bundle_w(DECODE_WIDTH)-1:0] i_bundle;
  logic                              o_ready;
  logic                              o_valid;
  logic                              o_illegal;
  uop_t [DECODE_WIDTH-1:0]           o_uops;
  integer                            seed = 9933;

  tb_clk_gen #(
    .PERIOD_NS   (20),
    .RESET_CYCLES(16)
  ) u_clk_gen (
    .o_clk(clk),
    .o_rst(rst)
  );

  rv_decode_top #(
    .DECODE_WIDTH(DECODE_WIDTH)
  ) UUT (
    .i_clk    (clk),
    .i_rst    (rst),
    .i_valid  (i_valid),
    .i_bundle (i_bundle),
    .i_ready  (i_ready),
    .o_ready  (o_ready),
    .o_valid  (o_valid),
    .o_uops   (o_uops),
    .o_illegal(o_illegal)
  );

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_uop(input string name, input uop_t got, input uop_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_fmt(input string name, input inst_fmt_e got, input inst_fmt_e exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %s expected %s",
                                  $time, name, got.name(), exp.name()));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                                  $time, name, got, exp));
    end
  endtask

  // expected micro-op, fields taken straight from the ISA bit positions
  function automatic uop_t model_uop(input logic [31:0] w, input logic [XLEN-1:0] pc,
                                     input inst_fmt_e fmt);
    uop_t u;
    u         = '0;
    u.fmt     = fmt;
    u.rs1_ren = fmt inside {FMT_R, FMT_I, FMT_S, FMT_B};
    u.rs2_ren = fmt inside {FMT_R, FMT_S, FMT_B};
    u.rd_wen  = fmt inside {FMT_R, FMT_I, FMT_U, FMT_J};
    u.rs1     = u.rs1_ren ? w[19:15] : 5'd0;
    u.rs2     = u.rs2_ren ? w[24:20] : 5'd0;
    u.rd      = u.rd_wen ? w[11:7] : 5'd0;
    case (fmt)
      FMT_I:    u.imm = {{52{w[31]}}, w[31:20]};
      FMT_S:    u.imm = {{52{w[31]}}, w[31:25], w[11:7]};
      FMT_B:    u.imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      FMT_U:    u.imm = {{32{w[31]}}, w[31:12], 12'b0};
      FMT_J:    u.imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      // csr zimm, zero extended
      FMT_CSRI: u.imm = {59'b0, w[19:15]};
      default:  u.imm = '0;
    endcase
    if (fmt == FMT_B || fmt == FMT_J) u.target = pc + u.imm;
    if (fmt != FMT_NONE && (w[6:0] == OPC_JAL || w[6:0] == OPC_JALR)) u.link = pc + 64'd4;
    return u;
  endfunction

  // random legal word: register and immediate bits random, opcode and functs fixed
  task automatic random_inst(output logic [31:0] w, output inst_fmt_e f);
    int          kind;
    logic [31:0] raw;
    kind = {$random(seed)} % 6;
    raw  = $random(seed);
    case (kind)
      0: begin
        w = (raw & 32'h01FF_8F80) | {25'b0, OPC_OP};
        f = FMT_R;
      end
      1: begin
        w = (raw & 32'hFFFF_8F80) | {25'b0, OPC_OP_IMM};
        f = FMT_I;
      end
      // sd
      2: begin
        w = (raw & 32'hFFFF_8F80) | 32'h0000_3000 | {25'b0, OPC_STORE};
        f = FMT_S;
      end
      // beq
      3: begin
        w = (raw & 32'hFFFF_8F80) | {25'b0, OPC_BRANCH};
        f = FMT_B;
      end
      4: begin
        w = (raw & 32'hFFFF_FF80) | {25'b0, OPC_LUI};
        f = FMT_U;
      end
      default: begin
        w = (raw & 32'hFFFF_FF80) | {25'b0, OPC_JAL};
        f = FMT_J;
      end
    endcase
  endtask

  task automatic wait_reset_done();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (rst !== 1'b0) begin
      if (cycles > TIMEOUT) begin
        stop_with_failure("reset was never released");
      end else begin
        @(posedge clk);
        cycles++;
      end
    end
    @(negedge clk);
  endtask

  // one bundle through an idle pipe with the sink always ready
  task automatic decode_pair(input logic [31:0] w0, input logic [31:0] w1,
                             input logic [XLEN-1:0] pc, input inst_fmt_e f0,
                             input inst_fmt_e f1, input bit exp_ill);
    bit accepted;
    int cycles;
    @(negedge clk);
    i_valid  = 1'b1;
    i_ready  = 1'b1;
    i_bundle = {w1, w0, pc};
    accepted = 1'b0;
    cycles   = 0;
    while (!accepted) begin
      #2;
      accepted = o_ready;
      if (!accepted) begin
        if (cycles > TIMEOUT) begin
          stop_with_failure("o_ready never rose to take a bundle");
        end else begin
          @(negedge clk);
          cycles++;
        end
      end
    end
    // the accepting edge passes here
    @(negedge clk);
    i_valid = 1'b0;
    cycles  = 1;
    while (!o_valid) begin
      if (cycles > TIMEOUT) begin
        stop_with_failure("o_valid never rose for an accepted bundle");
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
    check_count("latency", cycles, 2);
    check_fmt("o_uops[0].fmt", o_uops[0].fmt, f0);
    check_fmt("o_uops[1].fmt", o_uops[1].fmt, f1);
    check_uop("o_uops[0]", o_uops[0], model_uop(w0, pc, f0));
    check_uop("o_uops[1]", o_uops[1], model_uop(w1, pc + 64'd4, f1));
    check_flag("o_illegal", o_illegal, exp_ill);
  endtask

  task automatic idle_after_reset();
    check_flag("o_valid", o_valid, 1'b0);
    check_flag("o_ready", o_ready, 1'b1);
  endtask

  task automatic formats_and_enables();
    // add / addi, sd / beq, lui / jal, csrrwi / add
    decode_pair(32'h0020_81B3, 32'hFFF3_0293, 64'h1000, FMT_R, FMT_I, 1'b0);
    decode_pair(32'hFE71_3C23, 32'hFE20_88E3, 64'h2000, FMT_S, FMT_B, 1'b0);
    decode_pair(32'h8000_0537, 32'h0010_00EF, 64'h3000, FMT_U, FMT_J, 1'b0);
    decode_pair(32'h3003_D2F3, 32'h0020_81B3, 64'h4000, FMT_CSRI, FMT_R, 1'b0);
  endtask

  task automatic immediates_and_targets();
    // jalr link, jal backward from lane 1
    decode_pair(32'h00C2_80E7, 32'hFFDF_F06F, 64'h8000_0000_0000_0100, FMT_I, FMT_J, 1'b0);
    // lane pc and target carry past bit 31
    decode_pair(32'hFE20_88E3, 32'h0010_00EF, 64'h0000_0000_FFFF_FFF8, FMT_B, FMT_J, 1'b0);
    decode_pair(32'h1234_5217, 32'hFE71_3C23, 64'h0000_0000_0000_0040, FMT_U, FMT_S, 1'b0);
  endtask

  task automatic illegal_lane_words();
    decode_pair(32'h0000_007F, 32'h0020_81B3, 64'h5000, FMT_NONE, FMT_R, 1'b1);
    decode_pair(32'hFFF3_0293, 32'h0000_007F, 64'h6000, FMT_I, FMT_NONE, 1'b1);
  endtask

  // random bundles, random gaps and random sink stalls
  task automatic stalled_random_stream();
    uop_t            exp0_q[$];
    uop_t            exp1_q[$];
    uop_t            pend0;
    uop_t            pend1;
    uop_t            held0;
    uop_t            held1;
    logic            held_ill;
    logic [31:0]     w0;
    logic [31:0]     w1;
    logic [XLEN-1:0] pc;
    inst_fmt_e       f0;
    inst_fmt_e       f1;
    bit              pending;
    bit              stalled;
    int              sent;
    int              got;
    int              cycles;
    pending = 1'b0;
    stalled = 1'b0;
    sent    = 0;
    got     = 0;
    cycles  = 0;
    while (got < STREAM_LEN) begin
      if (cycles > STREAM_LEN * TIMEOUT) begin
        stop_with_failure("stream did not deliver every bundle in time");
      end else begin
        @(negedge clk);
        cycles++;
        if (stalled) begin
          check_flag("o_valid while stalled", o_valid, 1'b1);
          check_flag("o_illegal while stalled", o_illegal, held_ill);
          check_uop("o_uops[0] while stalled", o_uops[0], held0);
          check_uop("o_uops[1] while stalled", o_uops[1], held1);
        end
        if (!pending && sent < STREAM_LEN && ($random(seed) & 3) != 0) begin
          random_inst(w0, f0);
          random_inst(w1, f1);
          pc       = {$random(seed), $random(seed)} & ~64'h3;
          pend0    = model_uop(w0, pc, f0);
          pend1    = model_uop(w1, pc + 64'd4, f1);
          i_bundle = {w1, w0, pc};
          pending  = 1'b1;
        end
        i_valid = pending;
        i_ready = ($random(seed) & 3) != 0;
        // o_ready follows the new i_ready
        #2;
        // a bundle taken on this edge cannot also leave on it
        if (o_valid && i_ready) begin
          if (exp0_q.size() == 0) begin
            stop_with_failure("DUT delivered a bundle that was never sent");
          end else begin
            check_uop("o_uops[0]", o_uops[0], exp0_q.pop_front());
            check_uop("o_uops[1]", o_uops[1], exp1_q.pop_front());
            check_flag("o_illegal", o_illegal, 1'b0);
            got++;
          end
        end
        if (i_valid && o_ready) begin
          exp0_q.push_back(pend0);
          exp1_q.push_back(pend1);
          pending = 1'b0;
          sent++;
        end
        stalled  = o_valid && !i_ready;
        held0    = o_uops[0];
        held1    = o_uops[1];
        held_ill = o_illegal;
      end
    end
    // nothing left in flight
    @(negedge clk);
    i_ready = 1'b1;
    check_flag("o_valid after stream", o_valid, 1'b0);
  endtask

  initial begin
    i_valid  = 1'b0;
    i_ready  = 1'b0;
    i_bundle = '0;
    wait_reset_done();
    idle_after_reset();
    formats_and_enables();
    immediates_and_targets();
    illegal_lane_words();
    stalled_random_stream();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rv_decode_pkg.sv
decode_in_stage.sv
lane_decoder.sv
decode_out_stage.sv
rv_decode_top.sv
tb_clk_gen.sv
tb_rv_decode.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/10ps -j 0
TOP      := tb_rv_decode
FILELIST := src.f

SOURCES  := $(shell cat $(FILELIST))
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
